// File: common/lsu_pkg.sv
package lsu_pkg;

	// default data memory depth in 32-bit words
	localparam int RAM_WORDS_DEF = 256;

	// access size, same coding as funct3[1:0] of the load/store opcodes
	typedef enum logic [1:0] {
		WIDTH_BYTE = 2'b00,	// lb / lbu / sb
		WIDTH_HALF = 2'b01,	// lh / lhu / sh
		WIDTH_WORD = 2'b10	// lw / sw, 2'b11 left reserved
	} width_e;

	// one request as presented with req_valid_i
	typedef struct packed {
		logic        we;		// store when set
		width_e      width;		// access size
		logic        is_unsigned;	// zero extend on loads
		logic [31:0] addr;		// byte address
		logic [31:0] wdata;		// register data, low bits used for sb/sh
	} lsu_req_t;

	// load context held while the ram read is in flight
	typedef struct packed {
		logic [1:0] addr_lsbs;	// byte offset inside the word
		width_e     width;		// access size of the pending load
		logic       is_unsigned;	// extension mode of the pending load
	} ld_ctx_t;

endpackage

// File: design/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl #(
	parameter int RAM_WORDS = lsu_pkg::RAM_WORDS_DEF
) (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         req_valid_i,	// one request per cycle
	input  lsu_pkg::lsu_req_t            req_i,
	output logic                         store_en_o,	// legal store this cycle
	output logic [$clog2(RAM_WORDS)-1:0] ram_addr_o,	// word index into the ram
	output lsu_pkg::ld_ctx_t             ld_ctx_o,	// context of the pending load
	output logic                         ld_valid_o,	// load data ready this cycle
	output logic                         err_o		// refused request, one cycle
);

	localparam int AW = $clog2(RAM_WORDS);

	logic width_ok;	// width code is not reserved
	logic aligned;	// address fits the access size
	logic legal;	// request may touch memory
	logic load_go;	// legal load accepted this cycle

	// alignment check, the only one in the unit
	always_comb begin
		case (req_i.width)
			lsu_pkg::WIDTH_BYTE: begin
				width_ok = 1'b1;
				aligned  = 1'b1;	// any byte offset is fine
			end
			lsu_pkg::WIDTH_HALF: begin
				width_ok = 1'b1;
				aligned  = ~req_i.addr[0];	// even address only
			end
			lsu_pkg::WIDTH_WORD: begin
				width_ok = 1'b1;
				aligned  = (req_i.addr[1:0] == 2'b00);
			end
			default: begin
				width_ok = 1'b0;	// 2'b11 is reserved
				aligned  = 1'b0;
			end
		endcase
	end

	assign legal   = width_ok & aligned;
	assign load_go = req_valid_i & legal & ~req_i.we;

	assign store_en_o = req_valid_i & legal & req_i.we;	// ram writes on this edge
	assign ram_addr_o = req_i.addr[AW+1:2];	// drop byte offset

	// response pulses, valid and error never overlap
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ld_valid_o <= 1'b0;
			err_o      <= 1'b0;
		end else begin
			ld_valid_o <= load_go;
			err_o      <= req_valid_i & ~legal;
		end
	end

	// context follows the ram read by one cycle
	always_ff @(posedge clk_i) begin
		if (load_go) begin
			ld_ctx_o.addr_lsbs   <= req_i.addr[1:0];
			ld_ctx_o.width       <= req_i.width;
			ld_ctx_o.is_unsigned <= req_i.is_unsigned;
		end
	end

endmodule

// File: design/store_align.sv
`timescale 1ns/1ps

module store_align (
	input  logic [31:0]     data_i,	// register data
	input  logic [1:0]      addr_lsbs_i,	// byte offset in the word
	input  lsu_pkg::width_e width_i,
	input  logic            wr_enable_i,	// legal store strobe
	output logic [31:0]     mem_wdata_o,	// lane-aligned write data
	output logic [3:0]      mem_wstrb_o	// per-byte write mask
);

	logic [3:0] lane_mask;	// mask before the enable

	// source is replicated across all lanes, the mask picks the live ones
	always_comb begin
		case (width_i)
			lsu_pkg::WIDTH_BYTE: begin
				mem_wdata_o = {4{data_i[7:0]}};
				case (addr_lsbs_i)
					2'b00:   lane_mask = 4'b0001;
					2'b01:   lane_mask = 4'b0010;
					2'b10:   lane_mask = 4'b0100;
					default: lane_mask = 4'b1000;
				endcase
			end
			lsu_pkg::WIDTH_HALF: begin
				mem_wdata_o = {2{data_i[15:0]}};
				if (addr_lsbs_i[1]) begin
					lane_mask = 4'b1100;	// upper half word
				end else begin
					lane_mask = 4'b0011;	// lower half word
				end
			end
			lsu_pkg::WIDTH_WORD: begin
				mem_wdata_o = data_i;
				lane_mask   = 4'b1111;
			end
			default: begin
				mem_wdata_o = data_i;	// reserved width writes nothing
				lane_mask   = 4'b0000;
			end
		endcase
	end

	assign mem_wstrb_o = {4{wr_enable_i}} & lane_mask;	// zero mask when idle

endmodule

// File: design/load_extract.sv
`timescale 1ns/1ps

module load_extract (
	input  logic [31:0]     mem_rdata_i,	// raw word from the ram
	input  logic [1:0]      addr_lsbs_i,	// byte offset of the load
	input  lsu_pkg::width_e width_i,
	input  logic            is_unsigned_i,	// zero extend when set
	output logic [31:0]     data_o		// value for the register file
);

	logic [7:0]  rd_byte;	// addressed byte
	logic [15:0] rd_half;	// addressed half word
	logic        byte_sign;	// fill bit for byte loads
	logic        half_sign;	// fill bit for half loads

	// byte picked by both lsbs
	always_comb begin
		case (addr_lsbs_i)
			2'b00:   rd_byte = mem_rdata_i[7:0];
			2'b01:   rd_byte = mem_rdata_i[15:8];
			2'b10:   rd_byte = mem_rdata_i[23:16];
			default: rd_byte = mem_rdata_i[31:24];
		endcase
	end

	// half word picked by bit 1 only
	assign rd_half = addr_lsbs_i[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

	assign byte_sign = ~is_unsigned_i & rd_byte[7];
	assign half_sign = ~is_unsigned_i & rd_half[15];

	always_comb begin
		case (width_i)
			lsu_pkg::WIDTH_BYTE: data_o = {{24{byte_sign}}, rd_byte};
			lsu_pkg::WIDTH_HALF: data_o = {{16{half_sign}}, rd_half};
			default:             data_o = mem_rdata_i;	// word passes through
		endcase
	end

endmodule

// File: design/byte_ram.sv
`timescale 1ns/1ps

module byte_ram #(
	parameter int WORDS = lsu_pkg::RAM_WORDS_DEF
) (
	input  logic                     clk_i,
	input  logic [$clog2(WORDS)-1:0] addr_i,	// word index
	input  logic [31:0]              wdata_i,	// lane-aligned write data
	input  logic [3:0]               wstrb_i,	// one enable per byte lane
	output logic [31:0]              rdata_o	// registered read word
);

	logic [31:0] mem [WORDS];	// contents undefined until written

	// byte lanes written independently
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < 4; i++) begin
			if (wstrb_i[i]) begin
				mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
	end

	// read every cycle, old data on a same-edge write
	always_ff @(posedge clk_i) begin
		rdata_o <= mem[addr_i];
	end

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
	parameter int RAM_WORDS = lsu_pkg::RAM_WORDS_DEF
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              req_valid_i,	// request strobe
	input  lsu_pkg::lsu_req_t req_i,
	output logic [31:0]       rdata_o,	// load result
	output logic              rdata_valid_o,	// one cycle after a legal load
	output logic              err_o		// misaligned or reserved width
);

	localparam int AW = $clog2(RAM_WORDS);

	logic             store_en;	// legal store this cycle
	logic [AW-1:0]    ram_addr;	// word index
	lsu_pkg::ld_ctx_t ld_ctx;	// registered load context
	logic [31:0]      mem_wdata;	// aligned store data
	logic [3:0]       mem_wstrb;	// store lane mask
	logic [31:0]      mem_rdata;	// raw ram word

	lsu_ctrl #(
		.RAM_WORDS (RAM_WORDS)
	) u_ctrl (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.store_en_o  (store_en),
		.ram_addr_o  (ram_addr),
		.ld_ctx_o    (ld_ctx),
		.ld_valid_o  (rdata_valid_o),	// response strobe straight out
		.err_o       (err_o)
	);

	store_align u_store (
		.data_i      (req_i.wdata),
		.addr_lsbs_i (req_i.addr[1:0]),
		.width_i     (req_i.width),
		.wr_enable_i (store_en),
		.mem_wdata_o (mem_wdata),
		.mem_wstrb_o (mem_wstrb)
	);

	byte_ram #(
		.WORDS (RAM_WORDS)
	) u_ram (
		.clk_i   (clk_i),
		.addr_i  (ram_addr),
		.wdata_i (mem_wdata),
		.wstrb_i (mem_wstrb),
		.rdata_o (mem_rdata)
	);

	// extraction uses the context of the previous cycle
	load_extract u_load (
		.mem_rdata_i   (mem_rdata),
		.addr_lsbs_i   (ld_ctx.addr_lsbs),
		.width_i       (ld_ctx.width),
		.is_unsigned_i (ld_ctx.is_unsigned),
		.data_o        (rdata_o)
	);

endmodule

// File: tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

	localparam int MAX_ENTRIES  = 64;	// room in the stimulus table
	localparam int RESET_CYCLES = 16;

	logic              clk_i;
	logic              rst_n_i;
	logic              req_valid_i;
	lsu_pkg::lsu_req_t req_i;
	logic [31:0]       rdata_o;
	logic              rdata_valid_o;
	logic              err_o;

	lsu_pkg::lsu_req_t tbl_req [MAX_ENTRIES];	// one request per entry
	int                tbl_group [MAX_ENTRIES];	// behavior the entry belongs to
	int                n_entries;
	logic [7:0]        model_mem [1024];	// byte-addressed reference memory
	logic [31:0]       rng_state;	// lcg state
	int                cycle_cnt = 0;
	int                cycle_limit = 0;	// set once the table is built
	int                n_pass;
	int                n_fail;

	logic        chk_busy;	// a response is due on this cycle
	int          chk_idx;	// entry whose response is due
	logic        exp_valid;
	logic        exp_err;
	logic [31:0] exp_data;

	lsu_top #(
		.RAM_WORDS (lsu_pkg::RAM_WORDS_DEF)
	) uut (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.req_valid_i   (req_valid_i),
		.req_i         (req_i),
		.rdata_o       (rdata_o),
		.rdata_valid_o (rdata_valid_o),
		.err_o         (err_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;	// 10 ns period
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = lcg_next(rng_state);
		return rng_state;
	endfunction

	function automatic int width_bytes(input lsu_pkg::width_e w);
		case (w)
			lsu_pkg::WIDTH_WORD: return 4;
			lsu_pkg::WIDTH_HALF: return 2;
			default:             return 1;
		endcase
	endfunction

	// alignment and width rules of the unit
	function automatic logic is_legal(input lsu_pkg::lsu_req_t r);
		if (r.width == lsu_pkg::WIDTH_HALF) return ~r.addr[0];
		if (r.width == lsu_pkg::WIDTH_WORD) return r.addr[1:0] == 2'b00;
		return r.width == lsu_pkg::WIDTH_BYTE;	// reserved code refused
	endfunction

	task automatic model_store(input lsu_pkg::lsu_req_t r);
		logic [9:0] a;
		for (int k = 0; k < width_bytes(r.width); k++) begin
			a = r.addr[9:0] + 10'(k);
			model_mem[a] = r.wdata[8*k +: 8];	// little endian lanes
		end
	endtask

	function automatic logic [31:0] model_load(input lsu_pkg::lsu_req_t r);
		logic [31:0] v;
		logic [9:0]  a;
		v = 32'd0;
		for (int k = 0; k < width_bytes(r.width); k++) begin
			a = r.addr[9:0] + 10'(k);
			v[8*k +: 8] = model_mem[a];
		end
		if (!r.is_unsigned && r.width == lsu_pkg::WIDTH_BYTE && v[7]) v[31:8] = '1;
		if (!r.is_unsigned && r.width == lsu_pkg::WIDTH_HALF && v[15]) v[31:16] = '1;
		return v;
	endfunction

	task automatic add_entry(input int grp, input logic we, input logic [1:0] wd,
			input logic uns, input logic [31:0] addr, input logic [31:0] data);
		tbl_req[n_entries].we          = we;
		tbl_req[n_entries].width       = lsu_pkg::width_e'(wd);
		tbl_req[n_entries].is_unsigned = uns;
		tbl_req[n_entries].addr        = addr;
		tbl_req[n_entries].wdata       = data;
		tbl_group[n_entries]           = grp;
		n_entries++;
	endtask

	task automatic store_entry(input int grp, input logic [1:0] wd,
			input logic [31:0] addr, input logic [31:0] data);
		add_entry(grp, 1'b1, wd, 1'b0, addr, data);
	endtask

	task automatic load_entry(input int grp, input logic [1:0] wd, input logic uns,
			input logic [31:0] addr);
		add_entry(grp, 1'b0, wd, uns, addr, 32'd0);
	endtask

	task automatic build_table();
		store_entry(1, lsu_pkg::WIDTH_WORD, 32'h40, rand_word());
		load_entry(1, lsu_pkg::WIDTH_WORD, 1'b0, 32'h40);
		store_entry(1, lsu_pkg::WIDTH_WORD, 32'h44, rand_word());
		load_entry(1, lsu_pkg::WIDTH_WORD, 1'b0, 32'h44);
		store_entry(2, lsu_pkg::WIDTH_WORD, 32'h48, rand_word());	// preset the word
		store_entry(2, lsu_pkg::WIDTH_BYTE, 32'h48, rand_word() | 32'h80);
		load_entry(2, lsu_pkg::WIDTH_WORD, 1'b0, 32'h48);	// upper lanes kept
		store_entry(2, lsu_pkg::WIDTH_BYTE, 32'h49, rand_word() & 32'hffffff7f);
		store_entry(2, lsu_pkg::WIDTH_BYTE, 32'h4a, rand_word() | 32'h80);
		store_entry(2, lsu_pkg::WIDTH_BYTE, 32'h4b, rand_word() & 32'hffffff7f);
		load_entry(2, lsu_pkg::WIDTH_WORD, 1'b0, 32'h48);
		for (int k = 0; k < 4; k++) begin
			load_entry(2, lsu_pkg::WIDTH_BYTE, 1'b0, 32'h48 + k);	// lb
			load_entry(2, lsu_pkg::WIDTH_BYTE, 1'b1, 32'h48 + k);	// lbu
		end
		store_entry(3, lsu_pkg::WIDTH_WORD, 32'h50, rand_word());
		store_entry(3, lsu_pkg::WIDTH_HALF, 32'h50, rand_word() | 32'h8000);
		store_entry(3, lsu_pkg::WIDTH_HALF, 32'h52, rand_word() & 32'hffff7fff);
		load_entry(3, lsu_pkg::WIDTH_WORD, 1'b0, 32'h50);
		store_entry(3, lsu_pkg::WIDTH_HALF, 32'h54, rand_word() & 32'hffff7fff);
		store_entry(3, lsu_pkg::WIDTH_HALF, 32'h56, rand_word() | 32'h8000);
		for (int k = 0; k < 4; k++) begin
			load_entry(3, lsu_pkg::WIDTH_HALF, 1'b0, 32'h50 + 2*k);	// lh
			load_entry(3, lsu_pkg::WIDTH_HALF, 1'b1, 32'h50 + 2*k);	// lhu
		end
		store_entry(4, lsu_pkg::WIDTH_HALF, 32'h51, rand_word());	// odd half
		store_entry(4, lsu_pkg::WIDTH_WORD, 32'h42, rand_word());
		store_entry(4, lsu_pkg::WIDTH_WORD, 32'h41, rand_word());
		store_entry(4, 2'b11, 32'h44, rand_word());	// reserved width
		load_entry(4, lsu_pkg::WIDTH_HALF, 1'b0, 32'h53);
		load_entry(4, lsu_pkg::WIDTH_WORD, 1'b0, 32'h47);
		load_entry(4, 2'b11, 1'b0, 32'h48);
		load_entry(4, lsu_pkg::WIDTH_WORD, 1'b0, 32'h40);	// targets unchanged
		load_entry(4, lsu_pkg::WIDTH_WORD, 1'b0, 32'h44);
		load_entry(4, lsu_pkg::WIDTH_WORD, 1'b0, 32'h50);
		store_entry(5, lsu_pkg::WIDTH_WORD, 32'h60, rand_word());
		load_entry(5, lsu_pkg::WIDTH_WORD, 1'b0, 32'h60);	// store then load
		store_entry(5, lsu_pkg::WIDTH_BYTE, 32'h61, rand_word() | 32'h80);
		load_entry(5, lsu_pkg::WIDTH_BYTE, 1'b0, 32'h61);
		store_entry(5, lsu_pkg::WIDTH_HALF, 32'h62, rand_word());
		load_entry(5, lsu_pkg::WIDTH_WORD, 1'b0, 32'h60);
		store_entry(5, lsu_pkg::WIDTH_WORD, 32'h64, rand_word());
		store_entry(5, lsu_pkg::WIDTH_BYTE, 32'h65, rand_word());
		load_entry(5, lsu_pkg::WIDTH_HALF, 1'b1, 32'h64);
		load_entry(5, lsu_pkg::WIDTH_BYTE, 1'b1, 32'h65);
		load_entry(5, lsu_pkg::WIDTH_WORD, 1'b0, 32'h64);
	endtask

	// drive one entry and note what must come back next cycle
	task automatic apply_entry(input int idx);
		lsu_pkg::lsu_req_t r;
		logic              legal;
		r           = tbl_req[idx];
		legal       = is_legal(r);
		req_valid_i = 1'b1;
		req_i       = r;
		exp_valid   = legal & ~r.we;
		exp_err     = ~legal;
		exp_data    = 32'd0;
		if (legal && !r.we) exp_data = model_load(r);
		if (legal && r.we) model_store(r);	// ram writes on the sampling edge
		chk_idx  = idx;
		chk_busy = 1'b1;
	endtask

	task automatic check_response();
		logic ok;
		ok = 1'b1;
		if (chk_busy) begin
			if (exp_valid && rdata_valid_o !== 1'b1) begin
				$display("%0t: entry %0d load gave no valid pulse", $time, chk_idx);
				ok = 1'b0;
			end
			if (!exp_valid && rdata_valid_o !== 1'b0) begin
				$display("%0t: entry %0d gave a valid pulse it should not", $time, chk_idx);
				ok = 1'b0;
			end
			if (exp_err && err_o !== 1'b1) begin
				$display("%0t: entry %0d was not refused with an error pulse", $time, chk_idx);
				ok = 1'b0;
			end
			if (!exp_err && err_o !== 1'b0) begin
				$display("%0t: entry %0d raised an unexpected error pulse", $time, chk_idx);
				ok = 1'b0;
			end
			if (exp_valid && rdata_valid_o === 1'b1 && rdata_o !== exp_data) begin
				$display("Mismatch at %0t: entry %0d rdata_o %h, expected %h",
					$time, chk_idx, rdata_o, exp_data);
				ok = 1'b0;
			end
			if (ok) begin
				n_pass++;
				$display("test %0d (behavior %0d) passed", chk_idx, tbl_group[chk_idx]);
			end else begin
				n_fail++;
				$display("test %0d (behavior %0d) failed", chk_idx, tbl_group[chk_idx]);
			end
			chk_busy = 1'b0;
		end
	endtask

	// watchdog over the whole run
	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		rst_n_i     = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		n_entries   = 0;
		n_pass      = 0;
		n_fail      = 0;
		chk_busy    = 1'b0;
		chk_idx     = 0;
		exp_valid   = 1'b0;
		exp_err     = 1'b0;
		exp_data    = 32'd0;
		rng_state   = 32'h9ca1610e;
		build_table();
		cycle_limit = RESET_CYCLES + 4 * n_entries + 20;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		if (rdata_valid_o !== 1'b0 || err_o !== 1'b0) begin
			$display("response strobes were not low after reset");
			n_fail++;
		end
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk_i);
			#1;	// outputs settled, inputs change here
			check_response();
			apply_entry(i);
		end
		@(posedge clk_i);
		#1;
		check_response();	// last entry
		req_valid_i = 1'b0;
		$display("%0d tests passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: compile.f
common/lsu_pkg.sv
design/lsu_ctrl.sv
design/store_align.sv
design/load_extract.sv
design/byte_ram.sv
design/lsu_top.sv
tests/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it and judge the log.
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing -f compile.f --top-module lsu_tb -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$build_dir/Vlsu_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $log_file"
	exit 1
fi
